/* sim.f */
source/mix_pkg.sv
source/layer_if.sv
source/mix_regs.sv
source/scr_layer_merge.sv
source/obj_prio_mix.sv
source/video_mixer_top.sv
tests/tb_video_mixer.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line.
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_mixer \
    -f sim.f -o vsim > build.log 2>&1 \
    && ./obj_dir/vsim > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* tests/tb_video_mixer.sv */
//======================================================================
// testbench for the colour mixing stage. drives axi4-lite and random
// pixel traffic, checks pxl against a queue-free two stage reference.
//======================================================================
`timescale 1ns/1ps

module tb_video_mixer;

    localparam int ADDR_W     = 4;
    localparam int CLK_PERIOD = 40;
    localparam int PIX_RUN    = 120;  // cycles of traffic per round.
    localparam int AXI_OP     = 8;    // rough cycles per axi access.
    localparam int BP_OP      = 30;   // same, with responses stalled.
    localparam int RUN_CYCLES = 20 + 10*AXI_OP + 6*(AXI_OP+PIX_RUN) + 6*(AXI_OP+10)
                                + 16*BP_OP + 20;
    localparam int MARGIN     = 1000;

    logic clk, rst_n;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic pxl_cen, obj_en;
    logic [10:0] scr1_pxl, scr2_pxl, scr3_pxl;
    logic [11:0] obj_pxl, pxl;

    string cur_test;
    int errs = 0, checks = 0, tests = 0, errs_at_start = 0;
    logic pix_run = 0, obj_mode = 0, bp_on = 0;
    logic [15:0] m_ctrl = 16'h01F9, m_prio = 16'h0000; // model register copies.
    logic [3:0] pend_addr;
    logic [15:0] pend_data;
    logic [1:0] pend_strb;
    logic [11:0] s1_scr = '0, s1_obj = '0, exp_pxl = '0; // model pipeline.
    logic s1_oen = 0;

    video_mixer_top #(.ADDR_W(ADDR_W)) video_mixer_top_i (.*);

    initial begin
        clk = 0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // front-most enabled non-blank layer, walked back to front.
    function automatic logic [11:0] ref_merge(input logic [15:0] ctrl,
            input logic [10:0] p1, input logic [10:0] p2, input logic [10:0] p3);
        logic [10:0] pix [4];
        logic [1:0]  id;
        logic [11:0] r;
        pix[0] = '0;
        pix[1] = p1;
        pix[2] = p2;
        pix[3] = p3;
        r = {3'd0, 9'h00F}; // backdrop.
        for (int s = 2; s >= 0; s--) begin
            id = ctrl[2*s +: 2];
            if (id != 0 && ctrl[5+id] && pix[id][3:0] != 4'hF) r = {1'b0, id, pix[id][8:0]};
        end
        return r;
    endfunction

    function automatic logic [11:0] ref_mix(input logic [15:0] prio, input logic [11:0] scr,
            input logic [11:0] obj, input logic oen);
        logic [3:0] sp;
        logic front;
        sp = (scr[10:9] == 0) ? 4'd7 : prio[4*scr[10:9] +: 4];
        front = ({1'b0, obj[11:9]} > sp) && (sp != 0);
        if (!oen) return scr;
        if (front) return (obj[3:0] == 4'hF) ? scr : {3'b000, obj[8:0]};
        return (scr[3:0] != 4'hF) ? scr : {3'b000, obj[8:0]};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] d,
            input logic [1:0] s);
        logic [15:0] mask;
        mask = {{8{s[1]}}, {8{s[0]}}};
        return (old & ~mask) | (d & mask);
    endfunction

    function automatic logic [10:0] rand_scr();
        logic [3:0] pen;
        pen = ($urandom % 2) ? 4'hF : 4'($urandom); // half the pens blank.
        return {7'($urandom), pen};
    endfunction

    function automatic logic [15:0] rand_prio();
        logic [15:0] p;
        p = 16'($urandom);
        for (int n = 1; n < 4; n++) begin
            if ($urandom % 3 == 0) p[4*n +: 4] = 4'd0;
        end
        return p;
    endfunction

    // new pixel set each enable, enable on alternate cycles.
    always @(posedge clk) begin
        if (pix_run) begin
            pxl_cen <= !pxl_cen;
            if (!pxl_cen) begin
                scr1_pxl <= rand_scr();
                scr2_pxl <= rand_scr();
                scr3_pxl <= rand_scr();
                obj_pxl  <= {3'($urandom), 5'($urandom), ($urandom % 3 == 0) ? 4'hF : 4'($urandom)};
                obj_en   <= obj_mode && ($urandom % 4 != 0);
            end
        end else begin
            pxl_cen <= 1'b0;
        end
    end

    always @(posedge clk) begin
        bready <= bp_on ? ($urandom % 3 == 0) : 1'b1; // random low stretches.
        rready <= bp_on ? ($urandom % 3 == 0) : 1'b1;
    end

    // reference model. register copies follow the write response handshake.
    always @(posedge clk) begin
        if (rst_n) begin
            if (bvalid && bready) begin
                if (pend_addr == 4'h0) m_ctrl = merge_bytes(m_ctrl, pend_data, pend_strb);
                if (pend_addr == 4'h4) m_prio = merge_bytes(m_prio, pend_data, pend_strb);
            end
            if (awvalid && awready) begin
                pend_addr = awaddr;
                pend_data = wdata[15:0];
                pend_strb = wstrb[1:0];
            end
            if (pxl_cen) begin
                checks++;
                assert (pxl === exp_pxl) else begin
                    $display("error %s pxl expected %h actual %h", cur_test, exp_pxl, pxl);
                    errs++;
                end
                exp_pxl = ref_mix(m_prio, s1_scr, s1_obj, s1_oen);
                s1_scr  = ref_merge(m_ctrl, scr1_pxl, scr2_pxl, scr3_pxl);
                s1_obj  = obj_pxl;
                s1_oen  = obj_en;
            end
        end
    end

    a_bresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $display("write response changed before it was accepted in %s", cur_test);
            errs++;
        end

    a_rresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $display("read response changed before it was accepted in %s", cur_test);
            errs++;
        end

    // address and data are taken together, and only with no response waiting.
    a_ready_rules: assert property (@(posedge clk) disable iff (!rst_n)
        (awready == wready) && (!awready || (awvalid && wvalid && !bvalid))
        && (arready == !rvalid))
        else begin
            $display("axi ready signals broke the handshake rules in %s", cur_test);
            errs++;
        end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
            errs++;
        end
    endtask

    task automatic axi_write(input logic [3:0] a, input logic [15:0] d, input logic [3:0] s,
            output logic [1:0] resp);
        awaddr  <= a;
        wdata   <= {16'h0000, d};
        wstrb   <= s;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!(bvalid && bready));
        resp = bresp;
    endtask

    task automatic axi_read(input logic [3:0] a, output logic [31:0] d, output logic [1:0] resp);
        araddr  <= a;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        do @(posedge clk); while (!(rvalid && rready));
        d    = rdata;
        resp = rresp;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errs_at_start = errs;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %s, %0d errors", cur_test,
                 (errs == errs_at_start) ? "ok" : "failed", errs - errs_at_start);
    endtask

    initial begin
        #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        int unsigned seed;
        seed     = $urandom(98632);
        rst_n    = 0;
        awaddr   = '0;
        awvalid  = 0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 0;
        araddr   = '0;
        arvalid  = 0;
        bready   = 1;
        rready   = 1;
        pxl_cen  = 0;
        obj_en   = 0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        scr3_pxl = '0;
        obj_pxl  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("reset");
        check_val("pxl", 32'h0, {20'h0, pxl});
        axi_read(4'h0, rd, resp);
        check_val("layer_ctrl", {23'd0, 3'b111, 2'd3, 2'd2, 2'd1}, rd); // order 1,2,3 all on.
        axi_read(4'h4, rd, resp);
        check_val("layer_prio", 32'h0, rd);
        check_val("read resp", 32'h0, {30'h0, resp});
        end_test();

        start_test("registers");
        axi_write(4'h4, 16'h1234, 4'b0011, resp);
        check_val("write resp", 32'h0, {30'h0, resp});
        axi_write(4'h4, 16'hFFEE, 4'b0001, resp); // low byte only.
        axi_write(4'h4, 16'h77AA, 4'b0010, resp); // high byte only.
        axi_read(4'h4, rd, resp);
        check_val("layer_prio bytes", 32'h77EE, rd);
        axi_write(4'h0, 16'h5500, 4'b0010, resp);
        axi_read(4'h0, rd, resp);
        check_val("layer_ctrl bytes", 32'h55F9, rd);
        axi_write(4'h8, 16'hFFFF, 4'b0011, resp);
        check_val("unmapped write resp", 32'h2, {30'h0, resp});
        axi_read(4'hC, rd, resp);
        check_val("unmapped read resp", 32'h2, {30'h0, resp});
        axi_read(4'h0, rd, resp);
        check_val("layer_ctrl kept", 32'h55F9, rd);
        axi_read(4'h4, rd, resp);
        check_val("layer_prio kept", 32'h77EE, rd);
        end_test();

        start_test("scroll");
        pix_run <= 1'b1;
        for (int r = 0; r < 3; r++) begin
            axi_write(4'h0, {7'd0, 3'($urandom), 6'($urandom)}, 4'b0011, resp);
            repeat (PIX_RUN) @(posedge clk);
        end
        end_test();

        start_test("priority");
        obj_mode <= 1'b1;
        for (int r = 0; r < 3; r++) begin
            axi_write(4'h4, rand_prio(), 4'b0011, resp);
            axi_write(4'h0, {7'd0, 3'($urandom), 6'($urandom)}, 4'b0011, resp);
            repeat (PIX_RUN) @(posedge clk);
        end
        end_test();

        start_test("live_writes");
        for (int r = 0; r < 6; r++) begin
            repeat ($urandom % 10) @(posedge clk);
            if ($urandom % 2) axi_write(4'h4, rand_prio(), 4'b0011, resp);
            else axi_write(4'h0, {7'd0, 3'($urandom), 6'($urandom)}, 4'b0011, resp);
        end
        repeat (20) @(posedge clk);
        pix_run <= 1'b0;
        end_test();

        start_test("backpressure");
        bp_on <= 1'b1;
        for (int r = 0; r < 8; r++) begin
            seed = {16'h0, rand_prio()};
            axi_write(4'h4, seed[15:0], 4'b0011, resp);
            check_val("write resp", 32'h0, {30'h0, resp});
            axi_read(4'h4, rd, resp);
            check_val("layer_prio", seed, rd);
        end
        bp_on <= 1'b0;
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
        if (errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/video_mixer_top.sv */
//======================================================================
// colour mixing stage of the tile and sprite video pipeline.
// cpu programs order and priorities over axi4-lite; pixels need 2 enables.
//======================================================================
`timescale 1ns/1ps

module video_mixer_top #(
    parameter int ADDR_W = 4 // axi address width.
) (
    input  logic              clk,
    input  logic              rst_n,
    // axi4-lite slave port.
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    // pixel path.
    input  logic              pxl_cen,
    input  mix_pkg::scr_pix_t scr1_pxl,
    input  mix_pkg::scr_pix_t scr2_pxl,
    input  mix_pkg::scr_pix_t scr3_pxl,
    input  mix_pkg::mix_pix_t obj_pxl,
    input  logic              obj_en,
    output mix_pkg::mix_pix_t pxl
);

    mix_pkg::reg16_t layer_ctrl; // order and enables.
    mix_pkg::reg16_t layer_prio; // priority nibbles.

    layer_if lyr_bus (); // merger to mixer.

    mix_regs #(.ADDR_W(ADDR_W)) regs_i (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .layer_ctrl(layer_ctrl), .layer_prio(layer_prio)
    );

    scr_layer_merge merge_i (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl),
        .obj_pxl(obj_pxl), .obj_en(obj_en),
        .layer_ctrl(layer_ctrl), .lyr(lyr_bus.source)
    );

    obj_prio_mix mix_i (
        .clk(clk), .rst_n(rst_n),
        .lyr(lyr_bus.sink), .layer_prio(layer_prio), .pxl(pxl)
    );

endmodule

/* source/obj_prio_mix.sv */
//======================================================================
// places the object in front of or behind the merged scroll pixel.
// uses the per-layer priority nibbles; one pixel enable of latency.
//======================================================================
`timescale 1ns/1ps

module obj_prio_mix (
    input  logic              clk,
    input  logic              rst_n,
    layer_if.sink             lyr,
    input  mix_pkg::reg16_t   layer_prio,
    output mix_pkg::mix_pix_t pxl
);

    logic [2:0]        obj_prio;  // object priority from its tag.
    logic [2:0]        scr_lyr;   // layer the scroll pixel came from.
    mix_pkg::prio_t    scr_prio;
    logic              obj_front;
    logic              scr_wins;
    mix_pkg::mix_pix_t next_pxl;

    assign obj_prio = lyr.obj_pxl[11:9];
    assign scr_lyr  = lyr.scr_pxl[11:9];

    // nibble 0 of the register is not used, the backdrop is fixed.
    always_comb begin
        case (scr_lyr)
            3'd1:    scr_prio = layer_prio[7:4];
            3'd2:    scr_prio = layer_prio[11:8];
            3'd3:    scr_prio = layer_prio[15:12];
            default: scr_prio = mix_pkg::BACKDROP_PRIO;
        endcase
    end

    // a zero nibble keeps the layer above every object.
    assign obj_front = ({1'b0, obj_prio} > scr_prio) && (scr_prio != 4'd0);

    // the winner falls back to the other pixel when its pen is blank.
    assign scr_wins = obj_front ? mix_pkg::is_blank(lyr.obj_pxl[3:0])
                                : !mix_pkg::is_blank(lyr.scr_pxl[3:0]);

    always_comb begin
        if (!lyr.obj_en || scr_wins) begin
            next_pxl = lyr.scr_pxl;
        end else begin
            next_pxl = {3'b000, lyr.obj_pxl[8:0]}; // drop the priority bits.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (lyr.pxl_cen) begin
            pxl <= next_pxl;
        end
    end

    // a visible layer with a zero nibble stays in front of every object.
    a_zero_prio: assert property (@(posedge clk) disable iff (!rst_n)
        lyr.pxl_cen && scr_prio == 4'd0 && !mix_pkg::is_blank(lyr.scr_pxl[3:0])
        |=> pxl == $past(lyr.scr_pxl))
        else $error("object drawn over a zero priority layer");

endmodule

/* source/scr_layer_merge.sv */
//======================================================================
// merges the three scroll layers into the front-most visible pixel.
// order and enables come from layer_ctrl; one pixel enable of latency.
//======================================================================
`timescale 1ns/1ps

module scr_layer_merge (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  mix_pkg::scr_pix_t scr1_pxl,
    input  mix_pkg::scr_pix_t scr2_pxl,
    input  mix_pkg::scr_pix_t scr3_pxl,
    input  mix_pkg::mix_pix_t obj_pxl,
    input  logic              obj_en,
    input  mix_pkg::reg16_t   layer_ctrl,
    layer_if.source           lyr
);

    mix_pkg::scr_pix_t pix_by_id [4]; // scroll pixels indexed by layer id.
    logic [3:0]        en_by_id;      // layer enables, id 0 never on.
    mix_pkg::lyr_id_t  front_id;
    logic [8:0]        front_col;

    assign pix_by_id[0] = '0; // backdrop has no pixel input.
    assign pix_by_id[1] = scr1_pxl;
    assign pix_by_id[2] = scr2_pxl;
    assign pix_by_id[3] = scr3_pxl;

    assign en_by_id = {layer_ctrl[8:6], 1'b0};

    // slot 0 is the front. the first enabled, non-blank slot wins.
    always_comb begin
        mix_pkg::lyr_id_t slot_id;
        logic             found;
        found     = 1'b0;
        front_id  = '0;                          // backdrop by default.
        front_col = mix_pkg::BACKDROP_COLOR;
        for (int s = 0; s < 3; s++) begin
            slot_id = mix_pkg::lyr_id_t'(layer_ctrl[2*s +: 2]);
            if (!found && en_by_id[slot_id] &&
                !mix_pkg::is_blank(pix_by_id[slot_id][3:0])) begin
                found     = 1'b1;
                front_id  = slot_id;
                front_col = pix_by_id[slot_id][8:0]; // colour field of the tag.
            end
        end
    end

    assign lyr.pxl_cen = pxl_cen; // mixer runs on the same enable.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lyr.scr_pxl <= '0;
            lyr.obj_en  <= 1'b0;
        end else if (pxl_cen) begin
            lyr.scr_pxl <= {1'b0, front_id, front_col};
            lyr.obj_en  <= obj_en;
        end
    end

    // object rides along so it meets its scroll pixel at the mixer.
    always_ff @(posedge clk) begin
        if (pxl_cen) lyr.obj_pxl <= obj_pxl;
    end

    // mixer indexes a 4-nibble register with this tag.
    // only the backdrop tag may carry a blank pen.
    a_lyr_range: assert property (@(posedge clk) disable iff (!rst_n)
        lyr.scr_pxl[11:9] <= 3'd3 &&
        (lyr.scr_pxl[10:9] == 2'd0 || !mix_pkg::is_blank(lyr.scr_pxl[3:0])))
        else $error("scroll layer tag out of range or on a blank pen");

endmodule

/* source/mix_regs.sv */
//======================================================================
// axi4-lite slave with the layer control and layer priority registers.
// one transaction of each kind at a time, 16 bits stored per register.
//======================================================================
`timescale 1ns/1ps

module mix_regs #(
    parameter int ADDR_W = 4 // axi address width.
) (
    input  logic                clk,
    input  logic                rst_n,
    // write address and data.
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    // write response.
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    // read address.
    input  logic [ADDR_W-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    // read data.
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    // register values for the pixel path.
    output mix_pkg::reg16_t     layer_ctrl,
    output mix_pkg::reg16_t     layer_prio
);

    logic            wr_go;    // address and data accepted together.
    logic            rd_go;
    logic            wr_ctrl;
    logic            wr_prio;
    logic            rd_ctrl;
    logic            rd_prio;
    mix_pkg::reg16_t wr_mask;  // byte lanes selected by wstrb.

    // both channels must be present and no response may be waiting.
    assign wr_go   = awvalid && wvalid && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign arready = !rvalid; // next read only after rdata is taken.
    assign rd_go   = arvalid && arready;

    assign wr_ctrl = awaddr == ADDR_W'(mix_pkg::LAYER_CTRL_OFS);
    assign wr_prio = awaddr == ADDR_W'(mix_pkg::LAYER_PRIO_OFS);
    assign rd_ctrl = araddr == ADDR_W'(mix_pkg::LAYER_CTRL_OFS);
    assign rd_prio = araddr == ADDR_W'(mix_pkg::LAYER_PRIO_OFS);

    assign wr_mask = {{8{wstrb[1]}}, {8{wstrb[0]}}}; // upper strobes unused.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_ctrl <= mix_pkg::LAYER_CTRL_RST;
            layer_prio <= mix_pkg::LAYER_PRIO_RST;
        end else if (wr_go) begin
            if (wr_ctrl) layer_ctrl <= (layer_ctrl & ~wr_mask) | (wdata[15:0] & wr_mask);
            if (wr_prio) layer_prio <= (layer_prio & ~wr_mask) | (wdata[15:0] & wr_mask);
        end
    end

    // write response, held until the master takes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= (wr_ctrl || wr_prio) ? mix_pkg::AXI_OKAY : mix_pkg::AXI_SLVERR;
        end
    end

    // read channel.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rresp <= (rd_ctrl || rd_prio) ? mix_pkg::AXI_OKAY : mix_pkg::AXI_SLVERR;
            rdata <= {16'h0000, rd_ctrl ? layer_ctrl : (rd_prio ? layer_prio : 16'h0000)};
        end
    end

    // a response must not change or vanish before the handshake.
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped before rready");

endmodule

/* source/layer_if.sv */
//======================================================================
// pixel rate link from the scroll merger to the priority mixer.
// the merger drives the source side, the mixer reads the sink side.
//======================================================================
`timescale 1ns/1ps

interface layer_if;

    logic              pxl_cen; // pixel clock enable, passed straight on.
    mix_pkg::mix_pix_t scr_pxl; // front-most scroll pixel tagged with its layer.
    mix_pkg::mix_pix_t obj_pxl; // object pixel, delayed one enable.
    logic              obj_en;  // object valid, delayed with obj_pxl.

    modport source (
        output pxl_cen,
        output scr_pxl,
        output obj_pxl,
        output obj_en
    );

    modport sink (
        input pxl_cen,
        input scr_pxl,
        input obj_pxl,
        input obj_en
    );

endinterface

/* source/mix_pkg.sv */
//======================================================================
// types and constants shared by the colour mixing stage.
// compile this package first; other files use mix_pkg::name.
//======================================================================
package mix_pkg;

    typedef logic [10:0] scr_pix_t; // scroll pixel, palette above, pen in 3:0.
    typedef logic [11:0] mix_pix_t; // layer or priority in 11:9, colour in 8:0.
    typedef logic [1:0]  lyr_id_t;  // 0 is the backdrop, 1 to 3 scroll layers.
    typedef logic [3:0]  prio_t;    // one nibble of the priority register.
    typedef logic [15:0] reg16_t;   // cpu visible register.

    // pen 0xf is see-through on every layer and on objects.
    localparam logic [3:0] BLANK_PEN = 4'hF;

    localparam prio_t      BACKDROP_PRIO  = 4'd7;    // priority of layer 0.
    localparam logic [8:0] BACKDROP_COLOR = 9'h00F;  // shown when no layer qualifies.

    // register map, byte offsets on the axi bus.
    localparam int unsigned LAYER_CTRL_OFS = 'h0;
    localparam int unsigned LAYER_PRIO_OFS = 'h4;

    // order 1,2,3 front to back with layers 1 to 3 enabled.
    localparam reg16_t LAYER_CTRL_RST = 16'h01F9;
    localparam reg16_t LAYER_PRIO_RST = 16'h0000;

    // axi response codes.
    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

    // true when the pen marks a transparent pixel.
    function automatic logic is_blank(input logic [3:0] pen);
        return pen == BLANK_PEN;
    endfunction

endpackage
